// File: include/synth_cfg.svh
`ifndef SYNTH_CFG_SVH
`define SYNTH_CFG_SVH

// voice array size
`define SYNTH_VOICES 8
`define SYNTH_V_WIDTH 3

// 8 clocks per bit keeps serial frames short in simulation
`define SYNTH_CLKS_PER_BIT 8

// all notes off controller number
`define SYNTH_CC_ALL_OFF 8'd123

`endif

// File: hw/midi_pkg.sv
`default_nettype none

package midi_pkg;

    typedef logic [7:0] midi_byte_t;            // one byte on the wire

    // kind of the current running status
    typedef enum logic [2:0] {
        NONE,                                   // nothing seen since reset
        NOTE_OFF,                               // 0x8n
        NOTE_ON,                                // 0x9n
        CTRL,                                   // 0xBn
        PRG_CHANGE,                             // 0xCn, one data byte
        PITCH,                                  // 0xEn, lsb then msb
        OTHER                                   // system and unhandled kinds
    } midi_kind_e;

endpackage

`default_nettype wire

// File: hw/voice_pkg.sv
`default_nettype none

`include "synth_cfg.svh"

package voice_pkg;

    typedef logic [`SYNTH_VOICES-1:0] voice_mask_t;     // one bit per voice
    typedef logic [`SYNTH_V_WIDTH-1:0] voice_idx_t;     // voice number
    typedef logic [`SYNTH_V_WIDTH:0] key_count_t;       // 0 .. SYNTH_VOICES

    typedef enum logic [1:0] {
        IDLE,                                           // wait for velocity trigger
        ALLOC,                                          // grab lowest free voice
        RELEASE,                                        // drop voice holding the key
        CLEAR_ALL                                       // all notes off
    } stack_state_e;

endpackage

`default_nettype wire

// File: hw/midi_uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "synth_cfg.svh"

module midi_uart_rx #(
    parameter int CLKS_PER_BIT = `SYNTH_CLKS_PER_BIT
) (
    input  wire                  reg_clk,
    input  wire                  rst_n,
    input  wire                  midi_rxd,
    output logic                 rx_byte_valid,
    output midi_pkg::midi_byte_t rx_byte
);
    import midi_pkg::*;

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] MID_CNT  = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e        state;
    logic             rxd_meta, rxd_sync;       // two flop synchronizer
    logic [CNT_W-1:0] clk_cnt;                  // clocks within a bit
    logic [2:0]       bit_idx;                  // data bit number
    midi_byte_t       shift_reg;                // lsb arrives first

    assign rx_byte = shift_reg;                 // stable while valid is high

    always_ff @(posedge reg_clk) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;                   // idle line is high
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= midi_rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge reg_clk) begin
        if (!rst_n) begin
            state         <= RX_IDLE;
            clk_cnt       <= '0;
            bit_idx       <= '0;
            rx_byte_valid <= 1'b0;
        end else begin
            rx_byte_valid <= 1'b0;
            clk_cnt       <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rxd_sync)
                        state <= RX_START;      // falling edge, maybe a start bit
                end
                RX_START: begin
                    if (clk_cnt == MID_CNT) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rxd_sync ? RX_IDLE : RX_DATA;    // glitch goes back
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == LAST_CNT) begin  // middle of a data bit
                        clk_cnt   <= '0;
                        shift_reg <= {rxd_sync, shift_reg[7:1]};
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == LAST_CNT) begin  // middle of the stop bit
                        state         <= RX_IDLE;
                        rx_byte_valid <= rxd_sync;  // framing error drops the byte
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // a frame is far longer than one clock
    a_valid_single: assert property (@(posedge reg_clk) disable iff (!rst_n)
        rx_byte_valid |=> !rx_byte_valid);

endmodule

`default_nettype wire

// File: hw/midi_in_mux.sv
`timescale 1ns/1ps
`default_nettype none

module midi_in_mux (
    input  wire                  reg_clk,
    input  wire                  rst_n,
    input  wire                  uart_usb_sel,      // 0 uart, 1 cpu
    input  wire [2:0]            socmidi_addr,
    input  wire midi_pkg::midi_byte_t socmidi_data_in,
    input  wire                  socmidi_write,
    input  wire                  rx_byte_valid,
    input  wire midi_pkg::midi_byte_t rx_byte,
    output logic                 byteready,
    output midi_pkg::midi_byte_t midi_in_data
);
    import midi_pkg::*;

    logic       cpu_wr;                         // write to the midi byte register
    logic       src_strobe;
    midi_byte_t src_byte;

    assign cpu_wr     = socmidi_write && (socmidi_addr == 3'd0);    // other addresses ignored
    assign src_strobe = uart_usb_sel ? cpu_wr : rx_byte_valid;
    assign src_byte   = uart_usb_sel ? socmidi_data_in : rx_byte;

    always_ff @(posedge reg_clk) begin
        if (!rst_n)
            byteready <= 1'b0;
        else
            byteready <= src_strobe;            // one cycle behind the source
    end

    always_ff @(posedge reg_clk) begin
        if (src_strobe)
            midi_in_data <= src_byte;           // held until the next byte
    end

endmodule

`default_nettype wire

// File: hw/seq_trigger.sv
`timescale 1ns/1ps
`default_nettype none

module seq_trigger (
    input  wire                  reg_clk,
    input  wire                  rst_n,
    input  wire [3:0]            midi_ch,
    input  wire                  byteready,
    input  wire midi_pkg::midi_byte_t midi_in_data,
    output logic                 seq_trigger,
    output midi_pkg::midi_byte_t seq_databyte,
    output midi_pkg::midi_byte_t first_databyte,
    output logic                 is_velocity,
    output midi_pkg::midi_kind_e cur_kind
);
    import midi_pkg::*;

    logic [3:0] cur_ch;                         // channel of running status
    logic       byte_pos;                       // 0 first data byte, 1 second
    logic       two_bytes;
    logic       chan_msg;                       // kind we pass on
    logic       is_status;
    logic       data_take;

    function automatic midi_kind_e decode_kind(input midi_byte_t st);
        case (st[7:4])
            4'h8:    decode_kind = NOTE_OFF;
            4'h9:    decode_kind = NOTE_ON;
            4'hB:    decode_kind = CTRL;
            4'hC:    decode_kind = PRG_CHANGE;
            4'hE:    decode_kind = PITCH;
            default: decode_kind = OTHER;       // 0xF0 and up, aftertouch
        endcase
    endfunction

    assign two_bytes = cur_kind inside {NOTE_OFF, NOTE_ON, CTRL, PITCH};
    assign chan_msg  = two_bytes || (cur_kind == PRG_CHANGE);
    assign is_status = midi_in_data[7];
    assign data_take = byteready && !is_status && chan_msg;

    always_ff @(posedge reg_clk) begin
        if (!rst_n) begin
            cur_kind    <= NONE;
            cur_ch      <= '0;
            byte_pos    <= 1'b0;
            seq_trigger <= 1'b0;
            is_velocity <= 1'b0;
        end else begin
            seq_trigger <= 1'b0;
            if (byteready && is_status) begin
                cur_kind <= decode_kind(midi_in_data);
                cur_ch   <= midi_in_data[3:0];
                byte_pos <= 1'b0;               // new message starts
            end else if (data_take) begin
                seq_trigger <= (cur_ch == midi_ch);         // other channels stay silent
                is_velocity <= byte_pos;        // never set for program change
                byte_pos    <= two_bytes && !byte_pos;      // wraps for running status
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        if (data_take) begin
            seq_databyte <= midi_in_data;
            if (!byte_pos)
                first_databyte <= midi_in_data; // key or controller number
        end
    end

    // data bytes of unknown or system messages never get through
    a_trig_kind: assert property (@(posedge reg_clk) disable iff (!rst_n)
        seq_trigger |-> !(cur_kind inside {NONE, OTHER}));

endmodule

`default_nettype wire

// File: hw/note_stack.sv
`timescale 1ns/1ps
`default_nettype none

`include "synth_cfg.svh"

module note_stack (
    input  wire                   reg_clk,
    input  wire                   rst_n,
    input  wire voice_pkg::voice_mask_t voice_free,
    input  wire                   seq_trigger,
    input  wire                   is_velocity,
    input  wire midi_pkg::midi_byte_t seq_databyte,
    input  wire midi_pkg::midi_byte_t first_databyte,
    input  wire midi_pkg::midi_kind_e cur_kind,
    output logic                  note_on,
    output voice_pkg::voice_idx_t cur_key_adr,
    output midi_pkg::midi_byte_t  cur_key_val,
    output midi_pkg::midi_byte_t  cur_vel_on,
    output midi_pkg::midi_byte_t  cur_vel_off,
    output voice_pkg::voice_mask_t keys_on,
    output voice_pkg::key_count_t active_keys
);
    import midi_pkg::*;
    import voice_pkg::*;

    stack_state_e state;
    midi_byte_t   key_reg [`SYNTH_VOICES];      // key held by each voice
    midi_byte_t   ev_key;                       // key of the pending event
    midi_byte_t   ev_vel;
    logic         ev_off;                       // pending event is a note off message
    logic         vel_event;                    // last byte of a 2 byte message
    logic         free_hit, match_hit;
    voice_idx_t   free_idx, match_idx;

    assign vel_event = seq_trigger && is_velocity;

    // loop runs high to low so the lowest hit stays
    always_comb begin
        free_hit  = 1'b0;
        free_idx  = '0;
        match_hit = 1'b0;
        match_idx = '0;
        for (int i = `SYNTH_VOICES - 1; i >= 0; i--) begin
            if (voice_free[i] && !keys_on[i]) begin
                free_hit = 1'b1;
                free_idx = voice_idx_t'(i);
            end
            if (keys_on[i] && (key_reg[i] == ev_key)) begin
                match_hit = 1'b1;
                match_idx = voice_idx_t'(i);
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        if (!rst_n) begin
            state       <= IDLE;
            note_on     <= 1'b0;
            keys_on     <= '0;
            active_keys <= '0;
        end else begin
            note_on <= 1'b0;
            state   <= IDLE;                    // every action takes one cycle
            case (state)
                ALLOC: begin
                    if (free_hit) begin         // no free voice drops the note
                        keys_on[free_idx] <= 1'b1;
                        active_keys       <= active_keys + 1'b1;
                        note_on           <= 1'b1;
                    end
                end
                RELEASE: begin
                    if (match_hit) begin
                        keys_on[match_idx] <= 1'b0;
                        active_keys        <= active_keys - 1'b1;
                    end
                end
                CLEAR_ALL: begin
                    keys_on     <= '0;
                    active_keys <= '0;
                end
                default: ;
            endcase
            if (vel_event) begin                // a new event may land in any state
                if (cur_kind == NOTE_ON && seq_databyte != 8'd0)
                    state <= ALLOC;
                else if (cur_kind == NOTE_ON || cur_kind == NOTE_OFF)
                    state <= RELEASE;           // zero velocity note on is a note off
                else if (cur_kind == CTRL && first_databyte == `SYNTH_CC_ALL_OFF)
                    state <= CLEAR_ALL;
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        if (vel_event) begin
            ev_key <= first_databyte;
            ev_vel <= seq_databyte;
            ev_off <= (cur_kind == NOTE_OFF);
        end
        if (state == ALLOC && free_hit) begin
            key_reg[free_idx] <= ev_key;
            cur_key_adr       <= free_idx;      // held until the next note on
            cur_key_val       <= ev_key;
            cur_vel_on        <= ev_vel;
        end
        if (state == RELEASE && match_hit && ev_off)
            cur_vel_off <= ev_vel;              // release velocity of a note off message
    end

    // counter and mask move together in ALLOC, RELEASE and CLEAR_ALL
    a_count_match: assert property (@(posedge reg_clk) disable iff (!rst_n)
        active_keys == key_count_t'($countones(keys_on)));

endmodule

`default_nettype wire

// File: hw/controller_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module controller_cmd (
    input  wire                  reg_clk,
    input  wire                  rst_n,
    input  wire                  seq_trigger,
    input  wire                  is_velocity,
    input  wire midi_pkg::midi_byte_t seq_databyte,
    input  wire midi_pkg::midi_byte_t first_databyte,
    input  wire midi_pkg::midi_kind_e cur_kind,
    output logic                 ctrl_cmd,
    output logic                 prg_ch_cmd,
    output logic                 pitch_cmd,
    output midi_pkg::midi_byte_t octrl,
    output midi_pkg::midi_byte_t octrl_data,
    output midi_pkg::midi_byte_t prg_ch_data
);
    import midi_pkg::*;

    logic ctrl_end, prg_end, pitch_end;         // last data byte of each kind

    assign ctrl_end  = seq_trigger && is_velocity && (cur_kind == CTRL);
    assign prg_end   = seq_trigger && (cur_kind == PRG_CHANGE);     // single data byte
    assign pitch_end = seq_trigger && is_velocity && (cur_kind == PITCH);

    always_ff @(posedge reg_clk) begin
        if (!rst_n) begin
            ctrl_cmd   <= 1'b0;
            prg_ch_cmd <= 1'b0;
            pitch_cmd  <= 1'b0;
        end else begin
            ctrl_cmd   <= ctrl_end;
            prg_ch_cmd <= prg_end;
            pitch_cmd  <= pitch_end;
        end
    end

    always_ff @(posedge reg_clk) begin
        if (ctrl_end || pitch_end) begin
            octrl      <= first_databyte;       // controller number or pitch lsb
            octrl_data <= seq_databyte;         // value or pitch msb
        end
        if (prg_end)
            prg_ch_data <= seq_databyte;        // program number
    end

endmodule

`default_nettype wire

// File: hw/synth_controller.sv
`timescale 1ns/1ps
`default_nettype none

module synth_controller (
    input  wire                   reg_clk,
    input  wire                   rst_n,
    input  wire [2:0]             socmidi_addr,
    input  wire midi_pkg::midi_byte_t socmidi_data_in,
    input  wire                   socmidi_write,
    input  wire                   midi_rxd,
    input  wire                   uart_usb_sel,
    input  wire [3:0]             midi_ch,
    input  wire voice_pkg::voice_mask_t voice_free,
    output logic                  note_on,
    output voice_pkg::voice_idx_t cur_key_adr,
    output midi_pkg::midi_byte_t  cur_key_val,
    output midi_pkg::midi_byte_t  cur_vel_on,
    output midi_pkg::midi_byte_t  cur_vel_off,
    output voice_pkg::voice_mask_t keys_on,
    output voice_pkg::key_count_t active_keys,
    output logic                  ctrl_cmd,
    output logic                  prg_ch_cmd,
    output logic                  pitch_cmd,
    output midi_pkg::midi_byte_t  octrl,
    output midi_pkg::midi_byte_t  octrl_data,
    output midi_pkg::midi_byte_t  prg_ch_data
);
    import midi_pkg::*;

    logic       rx_byte_valid;                  // uart byte strobe
    midi_byte_t rx_byte;
    logic       byteready;                      // selected byte stream
    midi_byte_t midi_in_data;
    logic       seq_trig;                       // one per accepted data byte
    midi_byte_t seq_databyte;
    midi_byte_t first_databyte;
    logic       is_velocity;
    midi_kind_e cur_kind;

    midi_uart_rx midi_uart_rx_inst (
        .reg_clk       (reg_clk),
        .rst_n         (rst_n),
        .midi_rxd      (midi_rxd),
        .rx_byte_valid (rx_byte_valid),
        .rx_byte       (rx_byte)
    );

    midi_in_mux midi_in_mux_inst (
        .reg_clk         (reg_clk),
        .rst_n           (rst_n),
        .uart_usb_sel    (uart_usb_sel),
        .socmidi_addr    (socmidi_addr),
        .socmidi_data_in (socmidi_data_in),
        .socmidi_write   (socmidi_write),
        .rx_byte_valid   (rx_byte_valid),
        .rx_byte         (rx_byte),
        .byteready       (byteready),
        .midi_in_data    (midi_in_data)
    );

    seq_trigger seq_trigger_inst (
        .reg_clk        (reg_clk),
        .rst_n          (rst_n),
        .midi_ch        (midi_ch),
        .byteready      (byteready),
        .midi_in_data   (midi_in_data),
        .seq_trigger    (seq_trig),
        .seq_databyte   (seq_databyte),
        .first_databyte (first_databyte),
        .is_velocity    (is_velocity),
        .cur_kind       (cur_kind)
    );

    note_stack note_stack_inst (
        .reg_clk        (reg_clk),
        .rst_n          (rst_n),
        .voice_free     (voice_free),
        .seq_trigger    (seq_trig),
        .is_velocity    (is_velocity),
        .seq_databyte   (seq_databyte),
        .first_databyte (first_databyte),
        .cur_kind       (cur_kind),
        .note_on        (note_on),
        .cur_key_adr    (cur_key_adr),
        .cur_key_val    (cur_key_val),
        .cur_vel_on     (cur_vel_on),
        .cur_vel_off    (cur_vel_off),
        .keys_on        (keys_on),
        .active_keys    (active_keys)
    );

    controller_cmd controller_cmd_inst (
        .reg_clk        (reg_clk),
        .rst_n          (rst_n),
        .seq_trigger    (seq_trig),
        .is_velocity    (is_velocity),
        .seq_databyte   (seq_databyte),
        .first_databyte (first_databyte),
        .cur_kind       (cur_kind),
        .ctrl_cmd       (ctrl_cmd),
        .prg_ch_cmd     (prg_ch_cmd),
        .pitch_cmd      (pitch_cmd),
        .octrl          (octrl),
        .octrl_data     (octrl_data),
        .prg_ch_data    (prg_ch_data)
    );

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);
    initial clk = 1'b0;                         // first edge is a rising one
    always #(PERIOD_NS / 2.0) clk = ~clk;
endmodule

`default_nettype wire

// File: tb/tb_synth_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "synth_cfg.svh"

module tb_synth_controller;
    import midi_pkg::*;
    import voice_pkg::*;

    localparam int NOTE_WAIT = 200;             // cycles for a cpu byte to land
    localparam int UART_WAIT = 2000;            // serial frames are slow

    logic        clk;
    logic        rst_n;
    logic [2:0]  socmidi_addr;
    midi_byte_t  socmidi_data_in;
    logic        socmidi_write;
    logic        midi_rxd;
    logic        uart_usb_sel;
    logic [3:0]  midi_ch;
    voice_mask_t voice_free;
    logic        note_on;
    voice_idx_t  cur_key_adr;
    midi_byte_t  cur_key_val, cur_vel_on, cur_vel_off;
    voice_mask_t keys_on;
    key_count_t  active_keys;
    logic        ctrl_cmd, prg_ch_cmd, pitch_cmd;
    midi_byte_t  octrl, octrl_data, prg_ch_data;

    int          seen [4];                      // ctrl, prg, pitch, note_on pulses seen
    int          expd [4];                      // pulses asked for by the trace
    logic [31:0] lcg_state;
    int          wait_limit;

    tb_clk_gen #(.PERIOD_NS(4.0)) tb_clk_gen_inst (.clk(clk));

    synth_controller synth_controller_inst (
        .reg_clk         (clk),
        .rst_n           (rst_n),
        .socmidi_addr    (socmidi_addr),
        .socmidi_data_in (socmidi_data_in),
        .socmidi_write   (socmidi_write),
        .midi_rxd        (midi_rxd),
        .uart_usb_sel    (uart_usb_sel),
        .midi_ch         (midi_ch),
        .voice_free      (voice_free),
        .note_on         (note_on),
        .cur_key_adr     (cur_key_adr),
        .cur_key_val     (cur_key_val),
        .cur_vel_on      (cur_vel_on),
        .cur_vel_off     (cur_vel_off),
        .keys_on         (keys_on),
        .active_keys     (active_keys),
        .ctrl_cmd        (ctrl_cmd),
        .prg_ch_cmd      (prg_ch_cmd),
        .pitch_cmd       (pitch_cmd),
        .octrl           (octrl),
        .octrl_data      (octrl_data),
        .prg_ch_data     (prg_ch_data)
    );

    // pulses read before the edge updates them
    always @(posedge clk) begin
        if (ctrl_cmd === 1'b1)
            seen[0] = seen[0] + 1;
        if (prg_ch_cmd === 1'b1)
            seen[1] = seen[1] + 1;
        if (pitch_cmd === 1'b1)
            seen[2] = seen[2] + 1;
        if (note_on === 1'b1)
            seen[3] = seen[3] + 1;
    end

    function automatic string pulse_name(input int k);
        case (k)
            0:       return "ctrl_cmd";
            1:       return "prg_ch_cmd";
            2:       return "pitch_cmd";
            default: return "note_on";
        endcase
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        abort_run($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic check_note(input voice_idx_t exp_adr, input midi_byte_t exp_key,
                              input midi_byte_t exp_vel);
        if (cur_key_adr !== exp_adr)
            report_mismatch("cur_key_adr", cur_key_adr, exp_adr);
        if (cur_key_val !== exp_key)
            report_mismatch("cur_key_val", cur_key_val, exp_key);
        if (cur_vel_on !== exp_vel)
            report_mismatch("cur_vel_on", cur_vel_on, exp_vel);
    endtask

    task automatic check_voices(input voice_mask_t exp_mask, input key_count_t exp_cnt);
        if (keys_on !== exp_mask)
            report_mismatch("keys_on", keys_on, exp_mask);
        if (active_keys !== exp_cnt)
            report_mismatch("active_keys", active_keys, exp_cnt);
    endtask

    task automatic check_cmd(input string name, input midi_byte_t got, input midi_byte_t exp);
        if (got !== exp)
            report_mismatch(name, got, exp);
    endtask

    task automatic cpu_write(input logic [2:0] addr, input midi_byte_t data);
        socmidi_addr    = addr;                 // called on a falling edge
        socmidi_data_in = data;
        socmidi_write   = 1'b1;
        @(negedge clk);
        socmidi_write   = 1'b0;
        @(negedge clk);                         // one idle cycle between bytes
    endtask

    task automatic uart_send(input midi_byte_t data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};             // stop, data lsb first, start
        for (int i = 0; i < 10; i++) begin
            midi_rxd = frame[i];
            repeat (`SYNTH_CLKS_PER_BIT) @(negedge clk);
        end
    endtask

    task automatic wait_pulse(input int k, input int limit);
        int cyc;
        cyc = 0;
        while (seen[k] == expd[k]) begin
            if (cyc >= limit)
                abort_run($sformatf("timeout: no %s pulse within %0d cycles",
                                    pulse_name(k), limit));
            @(negedge clk);
            cyc++;
        end
        expd[k] = expd[k] + 1;
        if (seen[k] != expd[k])
            abort_run($sformatf("%s pulsed more than once for one message", pulse_name(k)));
    endtask

    // pipeline is 4 cycles deep, 8 leaves margin
    task automatic settle_quiet();
        repeat (8) @(negedge clk);
        for (int k = 0; k < 4; k++) begin
            if (seen[k] != expd[k])
                abort_run($sformatf("%s pulsed %0d times where %0d were expected",
                                    pulse_name(k), seen[k], expd[k]));
        end
    endtask

    initial begin
        int          fd;
        int          rc;
        string       line;
        byte         op;
        logic [31:0] a0, a1, a2;
        midi_byte_t  vel;

        rst_n           = 1'b0;
        socmidi_addr    = '0;
        socmidi_data_in = '0;
        socmidi_write   = 1'b0;
        midi_rxd        = 1'b1;                 // idle line
        uart_usb_sel    = 1'b1;
        midi_ch         = '0;
        voice_free      = '1;
        lcg_state       = 32'ha47fdd37;
        wait_limit      = NOTE_WAIT;
        for (int k = 0; k < 4; k++) begin
            seen[k] = 0;
            expd[k] = 0;
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        fd = $fopen("tb/synth_trace.txt", "r");
        if (fd == 0)
            abort_run("cannot open the trace file tb/synth_trace.txt");
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc == 0)
                break;
            if (line.len() < 2 || line[0] == "#")
                continue;                       // blank or comment line
            rc = $sscanf(line, "%c %h %h %h", op, a0, a1, a2);
            case (op)
                "c": begin
                    cpu_write(3'd0, a0[7:0]);
                    wait_limit = NOTE_WAIT;
                end
                "w": cpu_write(a0[2:0], a1[7:0]);
                "u": begin
                    uart_send(a0[7:0]);
                    wait_limit = UART_WAIT;
                end
                "m": midi_ch = a0[3:0];
                "f": voice_free = voice_mask_t'(a0);
                "s": uart_usb_sel = a0[0];
                "n": begin
                    wait_pulse(3, wait_limit);
                    check_note(voice_idx_t'(a1), a0[7:0], a2[7:0]);
                end
                "r": begin
                    lcg_state = lcg_next(lcg_state);
                    vel = {1'b0, lcg_state[22:16]};
                    if (vel == 8'd0)
                        vel = 8'd1;             // zero would be a note off
                    cpu_write(3'd0, a0[7:0]);
                    cpu_write(3'd0, vel);
                    wait_limit = NOTE_WAIT;
                    wait_pulse(3, wait_limit);
                    check_note(voice_idx_t'(a1), a0[7:0], vel);
                end
                "k": begin
                    settle_quiet();
                    check_voices(voice_mask_t'(a0), key_count_t'(a1));
                end
                "o": begin
                    settle_quiet();
                    check_cmd("cur_vel_off", cur_vel_off, a0[7:0]);
                end
                "x": begin
                    if (a0 > 2)
                        abort_run("trace holds a command kind other than 0, 1 or 2");
                    wait_pulse(int'(a0), wait_limit);
                    if (a0 == 1) begin
                        check_cmd("prg_ch_data", prg_ch_data, a1[7:0]);
                    end else begin
                        check_cmd("octrl", octrl, a1[7:0]);     // pitch lsb too
                        check_cmd("octrl_data", octrl_data, a2[7:0]);
                    end
                end
                default: abort_run($sformatf("unknown record in trace: %s", line));
            endcase
        end
        $fclose(fd);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
hw/midi_pkg.sv
hw/voice_pkg.sv
hw/midi_uart_rx.sv
hw/midi_in_mux.sv
hw/seq_trigger.sv
hw/note_stack.sv
hw/controller_cmd.sv
hw/synth_controller.sv
tb/tb_clk_gen.sv
tb/tb_synth_controller.sv

// File: tb/synth_trace.txt
# records, args in hex: c byte | w addr byte | u byte | m ch | f voice_free | s uart_usb_sel
# n key voice vel | r key voice | k keys_on count | o vel_off | x kind(0 ctrl 1 prg 2 pitch) d1 d2
s 1
m 3
f ff
k 00 0
# writes to other addresses are ignored
w 1 93
w 2 3c
w 5 40
k 00 0
# only voices 0 2 4 5 6 7 may be used
f f5
c 93
c 3c
c 40
n 3c 0 40
c 93
c 40
c 50
n 40 2 50
k 05 2
# running status and a burst with generated velocities
c 43
c 60
n 43 4 60
r 45 5
r 47 6
r 48 7
k f5 6
# no free voice left
c 4a
c 30
k f5 6
# note off, zero velocity note on, unknown key
c 83
c 40
c 22
k f1 5
o 22
c 93
c 3c
c 00
k f0 4
c 83
c 11
c 10
k f0 4
o 22
c 93
c 30
c 7f
n 30 0 7f
k f1 5
# channel 5 is filtered out
c 95
c 50
c 40
c 51
c 41
k f1 5
f ff
c 93
c 52
c 11
n 52 1 11
k f3 6
# control, program and pitch commands
c b3
c 07
c 64
x 0 07 64
k f3 6
c c3
c 05
x 1 05 00
c 06
x 1 06 00
c e3
c 12
c 34
x 2 12 34
c b3
c 7b
c 00
x 0 7b 00
k 00 0
# serial source, cpu writes now ignored
s 0
c 93
c 20
c 30
k 00 0
u 93
u 3c
u 45
n 3c 0 45
k 01 1
u 83
u 3c
u 19
k 00 0
o 19
